//--- files.f
+incdir+.
ybus_pkg.sv
updateCapture.sv
rowMerge.sv
writeSequencer.sv
ybusUpdate.sv
ybusUpdate_sva.sv
ybusUpdate_tb.sv

//--- rowMerge.sv
// Inserts the diagonal and change values into the fetched rows.
// Purely combinational, each one-hot bit picks its own slot.
`timescale 1ns/1ps
`include "ybus_defines.svh"

module rowMerge
   import ybus_pkg::*;
(
   input  yRow_t               readData1,
   input  yRow_t               readData2,
   input  logic [`VAL_W-1:0]   diagValue,
   input  logic [`VAL_W-1:0]   changeValue,
   input  logic [`SLOTS-1:0]   diagOneHot,
   input  logic [`SLOTS-1:0]   nonDiagOneHot,
   input  logic                sameRow,
   output yRow_t               primaryRow,
   output yRow_t               storeRow
);

   // diagonal row, plus the change value when both land in one row
   always_comb
   begin
      primaryRow = readData1;
      for (int i = 0; i < `SLOTS; i++)
      begin
         if (sameRow && nonDiagOneHot[i])
         begin
            primaryRow.slot[i].value = changeValue;
         end
         if (diagOneHot[i])
         begin
            primaryRow.slot[i].value = diagValue; // diagonal wins on overlap
         end
      end
   end

   // non-diagonal row, only written back when the rows differ
   always_comb
   begin
      storeRow = readData2;
      for (int i = 0; i < `SLOTS; i++)
      begin
         if (nonDiagOneHot[i])
         begin
            storeRow.slot[i].value = changeValue;
         end
      end
   end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the Y-bus updater testbench with Verilator, then check the log.

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
   --top-module ybusUpdate_tb -f files.f -o ybusUpdateSim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/ybusUpdateSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
   echo "simulation exited with status $simStatus"
fi

if grep -q "SIMULATION PASSED" "$logFile"; then
   exit 0
fi
echo "pass message not found in $logFile"
exit 1

//--- updateCapture.sv
// Captures the two update sets on the done flags and presents the active one.
// Set 1 arrives with dpDone alone, set 2 with dpDone and cpDone together.
`timescale 1ns/1ps
`include "ybus_defines.svh"

module updateCapture
(
   input  logic                clock,
   input  logic                reset,
   input  logic                idle,
   input  logic                secondSet,
   input  logic                dpDone,
   input  logic                cpDone,
   input  logic [`ADDR_W-1:0]  diagAddr,
   input  logic [`ADDR_W-1:0]  nonDiagAddr,
   input  logic [`SLOTS-1:0]   diagOneHot,
   input  logic [`SLOTS-1:0]   nonDiagOneHot,
   input  logic [`VAL_W-1:0]   diagValue,
   output logic                setsReady,
   output logic [`ADDR_W-1:0]  selDiagAddr,
   output logic [`ADDR_W-1:0]  selNonDiagAddr,
   output logic [`SLOTS-1:0]   selDiagOneHot,
   output logic [`SLOTS-1:0]   selNonDiagOneHot,
   output logic [`VAL_W-1:0]   selDiagValue
);

   logic [`ADDR_W-1:0] diagAddr1;
   logic [`ADDR_W-1:0] diagAddr2;
   logic [`ADDR_W-1:0] nonDiagAddr1;
   logic [`ADDR_W-1:0] nonDiagAddr2;
   logic [`SLOTS-1:0]  diagOneHot1;
   logic [`SLOTS-1:0]  diagOneHot2;
   logic [`SLOTS-1:0]  nonDiagOneHot1;
   logic [`SLOTS-1:0]  nonDiagOneHot2;
   logic [`VAL_W-1:0]  diagValue1;
   logic [`VAL_W-1:0]  diagValue2;
   logic               capture1;
   logic               capture2;

   // flags are only taken while the sequencer is parked
   assign capture1  = idle && dpDone && !cpDone;
   assign capture2  = idle && dpDone && cpDone;
   assign setsReady = capture2; // both sets held from the next edge on

   // banks follow the reset only, not the module enable
   always_ff @(posedge clock)
   begin
      if (!reset)
      begin
         diagAddr1      <= '0;
         nonDiagAddr1   <= '0;
         diagOneHot1    <= '0;
         nonDiagOneHot1 <= '0;
         diagValue1     <= '0;
         diagAddr2      <= '0;
         nonDiagAddr2   <= '0;
         diagOneHot2    <= '0;
         nonDiagOneHot2 <= '0;
         diagValue2     <= '0;
      end
      else
      begin
         if (capture1)
         begin
            diagAddr1      <= diagAddr;
            nonDiagAddr1   <= nonDiagAddr;
            diagOneHot1    <= diagOneHot;
            nonDiagOneHot1 <= nonDiagOneHot;
            diagValue1     <= diagValue;
         end
         if (capture2)
         begin
            diagAddr2      <= diagAddr;
            nonDiagAddr2   <= nonDiagAddr;
            diagOneHot2    <= diagOneHot;
            nonDiagOneHot2 <= nonDiagOneHot;
            diagValue2     <= diagValue;
         end
      end
   end

   // active set for the sequencer and the merge
   assign selDiagAddr      = secondSet ? diagAddr2 : diagAddr1;
   assign selNonDiagAddr   = secondSet ? nonDiagAddr2 : nonDiagAddr1;
   assign selDiagOneHot    = secondSet ? diagOneHot2 : diagOneHot1;
   assign selNonDiagOneHot = secondSet ? nonDiagOneHot2 : nonDiagOneHot1;
   assign selDiagValue     = secondSet ? diagValue2 : diagValue1;

endmodule

//--- writeSequencer.sv
// Fetch and write-back sequencer for the two captured update sets.
// All memory-side outputs are registered and lag the state by one cycle.
`timescale 1ns/1ps
`include "ybus_defines.svh"

module writeSequencer
   import ybus_pkg::*;
(
   input  logic                clock,
   input  logic                reset,
   input  logic                moduleEnable,
   input  logic                setsReady,
   input  logic [`ADDR_W-1:0]  selDiagAddr,
   input  logic [`ADDR_W-1:0]  selNonDiagAddr,
   input  yRow_t               primaryRow,
   input  yRow_t               storeRow,
   output logic                idle,
   output logic                secondSet,
   output logic                sameRow,
   output yRow_t               writeData,
   output logic [`ADDR_W-1:0]  writeAddress,
   output logic [`ADDR_W-1:0]  readStoreAddr,
   output logic                weBit,
   output logic                writeDone
);

   seqState_t          state;
   seqState_t          afterSet;
   logic               lastWrite;
   logic [`ADDR_W-1:0] fetchStoreAddr;
   yRow_t              storeData;

   assign sameRow = (selDiagAddr == selNonDiagAddr);
   assign idle    = (state == stateIdle);

   // second row only needed when the rows differ
   assign fetchStoreAddr = sameRow ? `IDLE_ADDR : selNonDiagAddr;

   // final write of the active set
   assign lastWrite = (state == stateWriteStore) ||
                      ((state == stateWritePrimary) && sameRow);

   // set 1 loops back for set 2, set 2 ends the transaction
   assign afterSet = secondSet ? stateIdle : stateFetch;

   // disable acts like reset on the sequencer
   always_ff @(posedge clock)
   begin
      if (!reset || !moduleEnable)
      begin
         state         <= stateIdle;
         secondSet     <= 1'b0;
         writeData.raw <= '0;
         writeAddress  <= '0;
         readStoreAddr <= '0;
         weBit         <= 1'b0;
         writeDone     <= 1'b0;
      end
      else
      begin
         weBit     <= 1'b0;
         writeDone <= 1'b0;
         case (state)
            stateIdle:
            begin
               writeAddress  <= `IDLE_ADDR; // parked
               readStoreAddr <= `IDLE_ADDR;
               if (setsReady)
               begin
                  state <= stateFetch;
               end
            end
            stateFetch:
            begin
               writeAddress  <= selDiagAddr; // read port 1 follows this
               readStoreAddr <= fetchStoreAddr;
               state         <= stateWritePrimary;
            end
            stateWritePrimary:
            begin
               writeData     <= primaryRow;
               writeAddress  <= selDiagAddr;
               readStoreAddr <= fetchStoreAddr;
               weBit         <= 1'b1;
               state         <= sameRow ? afterSet : stateWriteStore;
            end
            stateWriteStore:
            begin
               writeData     <= storeData; // held since writePrimary
               writeAddress  <= selNonDiagAddr;
               readStoreAddr <= `IDLE_ADDR;
               weBit         <= 1'b1;
               state         <= afterSet;
            end
         endcase

         if (lastWrite)
         begin
            writeDone <= secondSet; // rides along with the final write
            secondSet <= !secondSet;
         end
      end
   end

   // non-diagonal row is read during writePrimary, written one cycle later
   always_ff @(posedge clock)
   begin
      if (state == stateWritePrimary)
      begin
         storeData <= storeRow;
      end
   end

endmodule

//--- ybusUpdate.sv
// Top of the Y-bus row updater: capture, merge and write sequencer.
// Y memory sits outside with combinational read on both ports.
`timescale 1ns/1ps
`include "ybus_defines.svh"

module ybusUpdate
   import ybus_pkg::*;
(
   input  logic                clock,
   input  logic                reset,
   input  logic                moduleEnable,
   input  logic                dpDone,
   input  logic                cpDone,
   input  logic [`ADDR_W-1:0]  diagAddr,
   input  logic [`ADDR_W-1:0]  nonDiagAddr,
   input  logic [`SLOTS-1:0]   diagOneHot,
   input  logic [`SLOTS-1:0]   nonDiagOneHot,
   input  logic [`VAL_W-1:0]   diagValue,
   input  logic [`VAL_W-1:0]   changeValue,
   input  yRow_t               readData1,
   input  yRow_t               readData2,
   output yRow_t               writeData,
   output logic [`ADDR_W-1:0]  writeAddress,
   output logic [`ADDR_W-1:0]  readStoreAddr,
   output logic                weBit,
   output logic                writeDone
);

   logic               idle;
   logic               secondSet;
   logic               sameRow;
   logic               setsReady;
   logic [`ADDR_W-1:0] selDiagAddr;
   logic [`ADDR_W-1:0] selNonDiagAddr;
   logic [`SLOTS-1:0]  selDiagOneHot;
   logic [`SLOTS-1:0]  selNonDiagOneHot;
   logic [`VAL_W-1:0]  selDiagValue;
   yRow_t              primaryRow;
   yRow_t              storeRow;

   updateCapture uCapture
   (
      .clock            (clock),
      .reset            (reset),
      .idle             (idle),
      .secondSet        (secondSet),
      .dpDone           (dpDone),
      .cpDone           (cpDone),
      .diagAddr         (diagAddr),
      .nonDiagAddr      (nonDiagAddr),
      .diagOneHot       (diagOneHot),
      .nonDiagOneHot    (nonDiagOneHot),
      .diagValue        (diagValue),
      .setsReady        (setsReady),
      .selDiagAddr      (selDiagAddr),
      .selNonDiagAddr   (selNonDiagAddr),
      .selDiagOneHot    (selDiagOneHot),
      .selNonDiagOneHot (selNonDiagOneHot),
      .selDiagValue     (selDiagValue)
   );

   rowMerge uMerge
   (
      .readData1        (readData1),
      .readData2        (readData2),
      .diagValue        (selDiagValue),
      .changeValue      (changeValue), // taken straight from the input
      .diagOneHot       (selDiagOneHot),
      .nonDiagOneHot    (selNonDiagOneHot),
      .sameRow          (sameRow),
      .primaryRow       (primaryRow),
      .storeRow         (storeRow)
   );

   writeSequencer uSequencer
   (
      .clock            (clock),
      .reset            (reset),
      .moduleEnable     (moduleEnable),
      .setsReady        (setsReady),
      .selDiagAddr      (selDiagAddr),
      .selNonDiagAddr   (selNonDiagAddr),
      .primaryRow       (primaryRow),
      .storeRow         (storeRow),
      .idle             (idle),
      .secondSet        (secondSet),
      .sameRow          (sameRow),
      .writeData        (writeData),
      .writeAddress     (writeAddress),
      .readStoreAddr    (readStoreAddr),
      .weBit            (weBit),
      .writeDone        (writeDone)
   );

endmodule

//--- ybusUpdate_sva.sv
// Protocol assertions for the write sequencer.
// Attached to every writeSequencer instance by the bind at the bottom.
`timescale 1ns/1ps

module ybusUpdate_sva
   import ybus_pkg::*;
(
   input logic      clock,
   input logic      reset,
   input seqState_t state,
   input logic      weBit,
   input logic      writeDone
);

   // done pulse rides on the final write
   doneWithWrite: assert property (@(posedge clock) disable iff (!reset)
      writeDone |-> weBit)
      else $error("writeDone raised without weBit");

   // outputs lag the state, so idle leaves no write behind
   noWriteAfterIdle: assert property (@(posedge clock) disable iff (!reset)
      (state == stateIdle) |=> !weBit)
      else $error("weBit high in the cycle after idle");

   donePulseWidth: assert property (@(posedge clock) disable iff (!reset)
      writeDone |=> !writeDone)
      else $error("writeDone longer than one cycle");

endmodule

bind writeSequencer ybusUpdate_sva sequencerChecks
(
   .clock     (clock),
   .reset     (reset),
   .state     (state),
   .weBit     (weBit),
   .writeDone (writeDone)
);

//--- ybusUpdate_tb.sv
// Testbench for the Y-bus row updater with memory model, golden rows and scenario table.
// Compile through files.f with ybusUpdate_tb as the top module.
`timescale 1ns/1ps
`include "ybus_defines.svh"

module ybusUpdate_tb;

   localparam int clockPeriod    = 100;
   localparam int resetCycles    = 8;
   localparam int numEntries     = 5;
   localparam int memRows        = 1 << `ADDR_W;
   localparam int setW           = 2*`ADDR_W + 2*`SLOTS + `VAL_W;
   localparam int watchdogCycles = resetCycles + 20*(numEntries + 1); // one more for disabled run

   // rows alternate set 1 and set 2
   // fields {diagAddr, nonDiagAddr, diagOneHot, nonDiagOneHot, diagValue}
   localparam logic [setW-1:0] setTable [0:2*numEntries-1] = '{
      {11'd10,   11'd10,   4'b0001, 4'b0100, 48'h1111_2222_3333}, // same row
      {11'd20,   11'd21,   4'b0010, 4'b1000, 48'h4444_5555_6666},
      {11'd30,   11'd31,   4'b0100, 4'b0001, 48'h7777_8888_9999},
      {11'd31,   11'd31,   4'b0100, 4'b0010, 48'hAAAA_BBBB_CCCC}, // keeps set 1 slot 0
      {11'd40,   11'd41,   4'b1000, 4'b0010, 48'hDDDD_EEEE_FFFF},
      {11'd41,   11'd40,   4'b0100, 4'b0001, 48'h0123_4567_89AB}, // both rows again
      {11'd50,   11'd50,   4'b0010, 4'b0010, 48'hCDEF_0123_4567}, // overlap
      {11'd60,   11'd61,   4'b0001, 4'b0000, 48'h89AB_CDEF_0123}, // empty code
      {11'd2046, 11'd0,    4'b0001, 4'b1000, 48'h5A5A_5A5A_5A5A},
      {11'd1023, 11'd1023, 4'b0000, 4'b0100, 48'hA5A5_A5A5_A5A5}
   };

   // one change value per entry since the DUT reads changeValue live
   localparam logic [`VAL_W-1:0] changeTable [0:numEntries-1] = '{
      48'hC0C0_0000_0001,
      48'hC0C0_0000_0002,
      48'hC0C0_0000_0003,
      48'hC0C0_0000_0004,
      48'hC0C0_0000_0005
   };

   logic                clock;
   logic                reset;
   logic                moduleEnable;
   logic                dpDone;
   logic                cpDone;
   logic [`ADDR_W-1:0]  diagAddr;
   logic [`ADDR_W-1:0]  nonDiagAddr;
   logic [`SLOTS-1:0]   diagOneHot;
   logic [`SLOTS-1:0]   nonDiagOneHot;
   logic [`VAL_W-1:0]   diagValue;
   logic [`VAL_W-1:0]   changeValue;
   logic [`ROW_W-1:0]   readData1;
   logic [`ROW_W-1:0]   readData2;
   logic [`ROW_W-1:0]   writeData;
   logic [`ADDR_W-1:0]  writeAddress;
   logic [`ADDR_W-1:0]  readStoreAddr;
   logic                weBit;
   logic                writeDone;
   logic [`ROW_W-1:0]   mem [0:memRows-1];
   logic [`ROW_W-1:0]   golden [0:memRows-1];
   logic [15:0]         lfsr = 16'd88;
   int                  writeCount = 0;
   int                  doneCount = 0;
   int                  expWrites = 0;
   int                  expDones = 0;

   ybusUpdate uut
   (
      .clock         (clock),
      .reset         (reset),
      .moduleEnable  (moduleEnable),
      .dpDone        (dpDone),
      .cpDone        (cpDone),
      .diagAddr      (diagAddr),
      .nonDiagAddr   (nonDiagAddr),
      .diagOneHot    (diagOneHot),
      .nonDiagOneHot (nonDiagOneHot),
      .diagValue     (diagValue),
      .changeValue   (changeValue),
      .readData1     (readData1),
      .readData2     (readData2),
      .writeData     (writeData),
      .writeAddress  (writeAddress),
      .readStoreAddr (readStoreAddr),
      .weBit         (weBit),
      .writeDone     (writeDone)
   );

   always #(clockPeriod/2) clock = ~clock;

   // Y memory with combinational read on both ports
   assign readData1 = mem[writeAddress];
   assign readData2 = mem[readStoreAddr];

   always @(posedge clock)
   begin
      if (weBit)
      begin
         mem[writeAddress] <= writeData;
      end
   end

   // counts the cycle that just ended
   always @(posedge clock)
   begin
      if (weBit)
      begin
         writeCount++;
      end
      if (writeDone)
      begin
         doneCount++;
         checkValue("weBit during writeDone", 256'(weBit), 256'(1'b1));
      end
   end

   initial
   begin
      #(watchdogCycles * clockPeriod);
      $display("timeout: the DUT did not finish its transactions in time");
      $display("SIMULATION FAILED");
      $fatal(1, "watchdog expired");
   end

   // taps 16, 14, 13, 11
   function automatic logic [15:0] lfsrNext(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [`ROW_W-1:0] placeValue(input logic [`ROW_W-1:0] row,
      input logic [`SLOTS-1:0] code, input logic [`VAL_W-1:0] value);
      logic [`ROW_W-1:0] result;
      result = row;
      for (int i = 0; i < `SLOTS; i++)
      begin
         if (code[i])
         begin
            result[i*`SLOT_W +: `VAL_W] = value; // reserved bits above stay
         end
      end
      return result;
   endfunction

   task automatic checkValue(input string what, input logic [`ROW_W-1:0] actual,
      input logic [`ROW_W-1:0] expected);
      if (actual !== expected)
      begin
         $display("** Error at time %0t: %s is %h, expected %h",
                  $time, what, actual, expected);
         $display("SIMULATION FAILED");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   // every memory-side output held at zero
   task automatic checkInactive(input string phase);
      checkValue($sformatf("weBit %s", phase), 256'(weBit), '0);
      checkValue($sformatf("writeDone %s", phase), 256'(writeDone), '0);
      checkValue($sformatf("writeData %s", phase), writeData, '0);
      checkValue($sformatf("writeAddress %s", phase), 256'(writeAddress), '0);
      checkValue($sformatf("readStoreAddr %s", phase), 256'(readStoreAddr), '0);
   endtask

   task automatic compareMemory();
      for (int r = 0; r < memRows; r++)
      begin
         checkValue($sformatf("memory row %0d", r), mem[r], golden[r]);
      end
      checkValue("write count", 256'(writeCount), 256'(expWrites));
      checkValue("writeDone count", 256'(doneCount), 256'(expDones));
   endtask

   task automatic driveSet(input logic [setW-1:0] entry);
      {diagAddr, nonDiagAddr, diagOneHot, nonDiagOneHot, diagValue} = entry;
   endtask

   // garbage on the set inputs and flags with changeValue left alone
   task automatic scrambleInputs();
      diagAddr      = ~diagAddr;
      nonDiagAddr   = diagAddr ^ 11'h155;
      diagOneHot    = ~diagOneHot;
      nonDiagOneHot = diagOneHot ^ 4'b0110;
      diagValue     = ~diagValue;
      dpDone        = 1'b1;
      cpDone        = ~cpDone;
   endtask

   task automatic applyGolden(input logic [setW-1:0] entry, input logic [`VAL_W-1:0] change);
      logic [`ADDR_W-1:0] diagRow;
      logic [`ADDR_W-1:0] otherRow;
      logic [`SLOTS-1:0]  diagCode;
      logic [`SLOTS-1:0]  otherCode;
      logic [`VAL_W-1:0]  value;
      {diagRow, otherRow, diagCode, otherCode, value} = entry;
      if (diagRow == otherRow)
      begin
         golden[diagRow] = placeValue(golden[diagRow], otherCode, change);
         golden[diagRow] = placeValue(golden[diagRow], diagCode, value); // diagonal last
         expWrites += 1;
      end
      else
      begin
         golden[diagRow]  = placeValue(golden[diagRow], diagCode, value);
         golden[otherRow] = placeValue(golden[otherRow], otherCode, change);
         expWrites += 2;
      end
   endtask

   task automatic runEntry(input int k);
      @(negedge clock);
      driveSet(setTable[2*k]);
      changeValue = changeTable[k];
      dpDone      = 1'b1;
      cpDone      = 1'b0;
      @(negedge clock);
      driveSet(setTable[2*k+1]);
      cpDone = 1'b1;
      @(negedge clock);
      while (!writeDone)
      begin
         scrambleInputs(); // flags while busy
         @(negedge clock);
      end
      dpDone = 1'b0;
      cpDone = 1'b0;
      applyGolden(setTable[2*k], changeTable[k]);
      applyGolden(setTable[2*k+1], changeTable[k]);
      expDones++;
      repeat (2) @(negedge clock); // final write lands and one idle cycle follows
      checkValue("parked writeAddress", 256'(writeAddress), 256'(`IDLE_ADDR));
      checkValue("parked readStoreAddr", 256'(readStoreAddr), 256'(`IDLE_ADDR));
      compareMemory();
   endtask

   initial
   begin
      logic [`ROW_W-1:0] row;
      clock         = 1'b0;
      reset         = 1'b0;
      moduleEnable  = 1'b1;
      dpDone        = 1'b0;
      cpDone        = 1'b0;
      diagAddr      = '0;
      nonDiagAddr   = '0;
      diagOneHot    = '0;
      nonDiagOneHot = '0;
      diagValue     = '0;
      changeValue   = '0;
      for (int r = 0; r < memRows; r++)
      begin
         for (int b = 0; b < `ROW_W; b++)
         begin
            lfsr   = lfsrNext(lfsr);
            row[b] = lfsr[0];
         end
         mem[r]    <= row;
         golden[r] = row;
      end

      repeat (resetCycles)
      begin
         @(negedge clock);
         checkInactive("in reset");
      end
      reset = 1'b1;

      // a full strobe pair while disabled must not reach the memory
      @(negedge clock);
      moduleEnable = 1'b0;
      driveSet(setTable[0]);
      dpDone = 1'b1;
      @(negedge clock);
      driveSet(setTable[1]);
      cpDone = 1'b1;
      @(negedge clock);
      dpDone = 1'b0;
      cpDone = 1'b0;
      repeat (10) // beyond the 7-cycle worst case
      begin
         @(negedge clock);
         checkInactive("while disabled");
      end
      compareMemory();
      moduleEnable = 1'b1;

      for (int k = 0; k < numEntries; k++)
      begin
         runEntry(k);
      end
      repeat (3) @(negedge clock);
      compareMemory();
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

//--- ybus_defines.svh
// Widths and constants for the Y-bus row updater.
// Included by the package, the RTL and the testbench.
`ifndef YBUS_DEFINES_SVH
`define YBUS_DEFINES_SVH

// one Y-memory row holds four admittance slots
`define ROW_W 256

// 2048-row Y memory
`define ADDR_W 11

// {real, imag} admittance value
`define VAL_W 48

// slot pitch inside a row
`define SLOT_W 64

// slots per row, also the one-hot code width
`define SLOTS 4

// parked address while no row is needed
`define IDLE_ADDR {`ADDR_W{1'b1}}

`endif

//--- ybus_pkg.sv
// Row and state types shared by the Y-bus updater and its checkers.
`include "ybus_defines.svh"

package ybus_pkg;

   // one 64-bit slot, value in the low bits
   typedef struct packed
   {
      logic [`SLOT_W-`VAL_W-1:0] reserved; // passes through untouched
      logic [`VAL_W-1:0]         value;    // {real, imag}
   } ySlot_t;

   // a row seen as a raw word or as four slots, slot 0 least significant
   typedef union packed
   {
      logic [`ROW_W-1:0]         raw;
      ySlot_t [`SLOTS-1:0]       slot;
   } yRow_t;

   // sequencer states
   typedef enum logic [1:0]
   {
      stateIdle,
      stateFetch,
      stateWritePrimary,
      stateWriteStore
   } seqState_t;

endpackage
